/* list.f */
src/sv32_pkg.sv
src/tlb_pkg.sv
src/tlb_entry_array.sv
src/tlb_lookup.sv
src/tlb_perm_check.sv
src/tlb_ctrl.sv
src/tlb_top.sv
tb/tb_tlb.sv

/* run.sh */
#!/bin/sh
# build and run the TLB testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_tlb -f list.f -o tb_tlb_sim
./obj_dir/tb_tlb_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* tb/tb_tlb.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tlb
    import sv32_pkg::*;
();

    localparam logic [21:0]      PPN_XOR   = 22'h15_a3c5;
    localparam logic [VPN_W-1:0] FAULT_VPN = 20'h0dead;  // walker reports an error here
    localparam int               TIMEOUT   = 100;

    logic               CLK = 1'b0;
    logic               nRST, req, fence;
    logic [31:0]        vaddr, fence_va;
    access_t            kind_in;
    priv_t              priv_in;
    logic [ASID_W-1:0]  satp_asid, fence_asid;
    logic               busy, fault_load, fault_store, fault_insn, fence_done, walk_req;
    logic [PADDR_W-1:0] paddr;
    logic [VPN_W-1:0]   walk_vpn;
    logic               walk_busy = 1'b1;
    logic               walk_fault = 1'b0;
    pte_t               walk_pte = '0;
    int                 walk_count = 0;
    int                 errors, timeouts;
    string              test_name;

    tlb_top dut0 (
        .CLK(CLK), .nRST(nRST), .req(req), .vaddr(vaddr), .access(kind_in),
        .priv(priv_in), .satp_asid(satp_asid), .busy(busy), .paddr(paddr),
        .fault_load(fault_load), .fault_store(fault_store), .fault_insn(fault_insn),
        .fence(fence), .fence_va(fence_va), .fence_asid(fence_asid),
        .fence_done(fence_done), .walk_req(walk_req), .walk_vpn(walk_vpn),
        .walk_busy(walk_busy), .walk_pte(walk_pte), .walk_fault(walk_fault)
    );

    always #50 CLK = ~CLK;

    // leaf pte the walker returns, flags picked by vpn[6:4]
    function automatic pte_t pte_for(input logic [VPN_W-1:0] vpn);
        logic [7:0] flags;  // d a g u x w r v
        case (vpn[6:4])
            3'd0:    flags = 8'hcf;  // rwx supervisor
            3'd1:    flags = 8'hc3;  // read only
            3'd2:    flags = 8'hcb;  // rx, no write
            3'd3:    flags = 8'hd7;  // rw user
            3'd4:    flags = 8'hef;  // global rwx supervisor
            3'd5:    flags = 8'hdf;
            3'd6:    flags = 8'hc9;  // execute only
            default: flags = 8'hf7;
        endcase
        return pte_t'({{2'b00, vpn} ^ PPN_XOR, 2'b00, flags});
    endfunction

    function automatic logic [PADDR_W-1:0] expected_paddr(input logic [31:0] va);
        return {{2'b00, va[31:OFFSET_W]} ^ PPN_XOR, va[OFFSET_W-1:0]};
    endfunction

    // behavioural page walker with a random stall
    always begin : walker
        logic [VPN_W-1:0] vpn;
        @(negedge CLK);
        #2;  // after the requester has driven
        if (nRST && walk_req) begin
            walk_count++;
            vpn = walk_vpn;
            repeat ($urandom_range(4, 1)) @(negedge CLK);
            walk_pte   = pte_for(vpn);
            walk_fault = (vpn == FAULT_VPN);
            walk_busy  = 1'b0;
            @(negedge CLK);
            walk_busy  = 1'b1;
            walk_fault = 1'b0;
        end
    end

    task automatic check_paddr(input logic [PADDR_W-1:0] got, input logic [PADDR_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s: paddr %h, expected %h", $time, test_name, got, exp);
        end
    endtask

    task automatic check_faults(input access_t kind, input logic exp_fault,
                                input logic fl, input logic fs, input logic fi);
        logic [2:0] exp;
        exp = {exp_fault && (kind == ACCESS_LOAD), exp_fault && (kind == ACCESS_STORE),
               exp_fault && (kind == ACCESS_FETCH)};
        if ({fl, fs, fi} !== exp) begin
            errors++;
            $display("FAILED at %0t: %s: faults l/s/i %b, expected %b",
                     $time, test_name, {fl, fs, fi}, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            errors++;
            $display("FAILED at %0t: %s: %0d %s, expected %0d",
                     $time, test_name, got, what, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("ERROR at %0t: %s: DUT did not respond (%s)", $time, test_name, what);
    endtask

    // one translation, held until busy drops
    task automatic access(input logic [31:0] va, input access_t kind, input priv_t pv,
                          input logic [ASID_W-1:0] asid, input logic exp_fault,
                          input int exp_walks);
        int   n;
        int   walks0;
        logic got;
        walks0 = walk_count;
        got    = 1'b0;
        n      = 0;
        @(negedge CLK);
        req       = 1'b1;
        vaddr     = va;
        kind_in   = kind;
        priv_in   = pv;
        satp_asid = asid;
        while (!got && n < TIMEOUT) begin
            #1;
            if (!busy) begin
                got = 1'b1;
                check_faults(kind, exp_fault, fault_load, fault_store, fault_insn);
                if (va[31:OFFSET_W] != FAULT_VPN) begin
                    check_paddr(paddr, expected_paddr(va));
                end
            end else begin
                @(negedge CLK);
                n++;
            end
        end
        if (!got) report_timeout("translation");
        @(negedge CLK);
        req = 1'b0;
        check_count(walk_count - walks0, exp_walks, "page walks");
    endtask

    task automatic do_fence(input logic [31:0] va, input logic [ASID_W-1:0] asid);
        int   n;
        logic got;
        got = 1'b0;
        n   = 0;
        @(negedge CLK);
        fence      = 1'b1;
        fence_va   = va;
        fence_asid = asid;
        while (!got && n < TIMEOUT) begin
            #1;
            if (fence_done) begin
                got = 1'b1;
            end else begin
                @(negedge CLK);
                n++;
            end
        end
        if (!got) report_timeout("fence");
        @(negedge CLK);
        fence = 1'b0;
    endtask

    task automatic test_hit_reuse();
        test_name = "hit reuse";
        access(32'h1230_1abc, ACCESS_LOAD, PRIV_SUPERVISOR, 9'd1, 1'b0, 1);
        access(32'h1230_1abc, ACCESS_LOAD, PRIV_SUPERVISOR, 9'd1, 1'b0, 0);
    endtask

    task automatic test_asid_tag();
        test_name = "asid tag";
        access(32'h1230_1abc, ACCESS_LOAD, PRIV_SUPERVISOR, 9'd5, 1'b0, 1);
        access(32'h1230_1abc, ACCESS_LOAD, PRIV_SUPERVISOR, 9'd1, 1'b0, 0);
        access(32'h1230_1abc, ACCESS_LOAD, PRIV_SUPERVISOR, 9'd5, 1'b0, 0);
    endtask

    // a, b, c all in set 2
    task automatic test_replacement();
        test_name = "replacement";
        access(32'h0010_2010, ACCESS_LOAD, PRIV_SUPERVISOR, 9'd1, 1'b0, 1);
        access(32'h0020_2020, ACCESS_LOAD, PRIV_SUPERVISOR, 9'd1, 1'b0, 1);
        access(32'h0030_2030, ACCESS_LOAD, PRIV_SUPERVISOR, 9'd1, 1'b0, 1);  // evicts a
        access(32'h0020_2020, ACCESS_LOAD, PRIV_SUPERVISOR, 9'd1, 1'b0, 0);
        access(32'h0010_2010, ACCESS_LOAD, PRIV_SUPERVISOR, 9'd1, 1'b0, 1);
    endtask

    task automatic test_permissions();
        test_name = "permissions";
        access(32'h0006_3100, ACCESS_LOAD, PRIV_SUPERVISOR, 9'd1, 1'b1, 1);
        access(32'h0006_3100, ACCESS_FETCH, PRIV_SUPERVISOR, 9'd1, 1'b0, 0);
        access(32'h0002_4200, ACCESS_STORE, PRIV_SUPERVISOR, 9'd1, 1'b1, 1);
        access(32'h0002_4200, ACCESS_LOAD, PRIV_SUPERVISOR, 9'd1, 1'b0, 0);
        access(32'h0001_5300, ACCESS_FETCH, PRIV_SUPERVISOR, 9'd1, 1'b1, 1);
        access(32'h0001_5300, ACCESS_LOAD, PRIV_SUPERVISOR, 9'd1, 1'b0, 0);
        access(32'h0003_6400, ACCESS_LOAD, PRIV_SUPERVISOR, 9'd1, 1'b1, 1);  // user page
        access(32'h0003_6400, ACCESS_LOAD, PRIV_USER, 9'd1, 1'b0, 0);
        access(32'h0003_6400, ACCESS_STORE, PRIV_USER, 9'd1, 1'b0, 0);
    endtask

    task automatic test_fences();
        test_name = "fence by va";
        do_fence(32'h1230_1abc, 9'd0);
        access(32'h1230_1abc, ACCESS_LOAD, PRIV_SUPERVISOR, 9'd1, 1'b0, 1);
        access(32'h0010_2010, ACCESS_LOAD, PRIV_SUPERVISOR, 9'd1, 1'b0, 0);
        test_name = "fence by asid";
        access(32'h0004_7500, ACCESS_LOAD, PRIV_SUPERVISOR, 9'd1, 1'b0, 1);  // global page
        access(32'h0000_8600, ACCESS_LOAD, PRIV_SUPERVISOR, 9'd5, 1'b0, 1);
        do_fence(32'h0, 9'd1);
        access(32'h0004_7500, ACCESS_LOAD, PRIV_SUPERVISOR, 9'd1, 1'b0, 0);
        access(32'h0010_2010, ACCESS_LOAD, PRIV_SUPERVISOR, 9'd1, 1'b0, 1);
        access(32'h0000_8600, ACCESS_LOAD, PRIV_SUPERVISOR, 9'd5, 1'b0, 0);
        test_name = "fence all";
        do_fence(32'h0, 9'd0);
        access(32'h0004_7500, ACCESS_LOAD, PRIV_SUPERVISOR, 9'd1, 1'b0, 1);
        access(32'h0000_8600, ACCESS_LOAD, PRIV_SUPERVISOR, 9'd5, 1'b0, 1);
    endtask

    task automatic test_walk_fault();
        test_name = "walk fault";
        access(32'h0dea_d700, ACCESS_STORE, PRIV_SUPERVISOR, 9'd1, 1'b1, 1);
        access(32'h0dea_d700, ACCESS_STORE, PRIV_SUPERVISOR, 9'd1, 1'b1, 1);  // nothing filled
    endtask

    initial begin
        void'($urandom(32'h0a76_16db));
        nRST       = 1'b0;
        req        = 1'b0;
        vaddr      = '0;
        kind_in    = ACCESS_LOAD;
        priv_in    = PRIV_SUPERVISOR;
        satp_asid  = '0;
        fence      = 1'b0;
        fence_va   = '0;
        fence_asid = '0;
        errors     = 0;
        timeouts   = 0;
        test_name  = "reset";
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        test_hit_reuse();
        test_asid_tag();
        test_replacement();
        test_permissions();
        test_fences();
        test_walk_fault();
        $display("error counts: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/tlb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_top
    import sv32_pkg::*;
    import tlb_pkg::*;
#(
    parameter int SETS = DEF_SETS,
    parameter int WAYS = DEF_WAYS,
    localparam int SET_W = (SETS > 1) ? $clog2(SETS) : 1,
    localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1
) (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               req,
    input  logic [31:0]        vaddr,
    input  access_t            access,
    input  priv_t              priv,
    input  logic [ASID_W-1:0]  satp_asid,
    output logic               busy,
    output logic [PADDR_W-1:0] paddr,
    output logic               fault_load,
    output logic               fault_store,
    output logic               fault_insn,
    input  logic               fence,
    input  logic [31:0]        fence_va,
    input  logic [ASID_W-1:0]  fence_asid,
    output logic               fence_done,
    output logic               walk_req,
    output logic [VPN_W-1:0]   walk_vpn,
    input  logic               walk_busy,
    input  pte_t               walk_pte,
    input  logic               walk_fault
);

    tlb_entry_t [WAYS-1:0] rd_entries;
    logic [WAYS-1:0]       rd_valid;
    logic [WAYS-1:0]       inval_mask;
    logic [SET_W-1:0]      rd_set, wr_set;
    logic [WAY_W-1:0]      hit_way, victim_way, wr_way, touch_way;
    tlb_entry_t            hit_entry, wr_entry;
    logic                  hit, wr_en, wr_fill, touch_en, walk_fault_out;
    logic                  hit_resp;

    assign hit_resp = hit && !busy;  // answering from a stored entry
    assign paddr    = {hit_entry.pte.ppn, vaddr[OFFSET_W-1:0]};

    tlb_ctrl #(.SETS(SETS), .WAYS(WAYS)) ctrl0 (
        .CLK(CLK), .nRST(nRST), .req(req), .vaddr(vaddr), .satp_asid(satp_asid),
        .fence(fence), .fence_va(fence_va), .fence_asid(fence_asid),
        .hit(hit), .hit_way(hit_way), .rd_entries(rd_entries), .rd_valid(rd_valid),
        .victim_way(victim_way), .walk_busy(walk_busy), .walk_pte(walk_pte),
        .walk_fault(walk_fault), .busy(busy), .fence_done(fence_done),
        .walk_req(walk_req), .walk_vpn(walk_vpn), .walk_fault_out(walk_fault_out),
        .rd_set(rd_set), .wr_en(wr_en), .wr_fill(wr_fill), .wr_set(wr_set),
        .wr_way(wr_way), .wr_entry(wr_entry), .inval_mask(inval_mask),
        .touch_en(touch_en), .touch_way(touch_way)
    );

    tlb_entry_array #(.SETS(SETS), .WAYS(WAYS)) array0 (
        .CLK(CLK), .nRST(nRST), .rd_set(rd_set), .wr_en(wr_en), .wr_fill(wr_fill),
        .wr_set(wr_set), .wr_way(wr_way), .wr_entry(wr_entry), .inval_mask(inval_mask),
        .touch_en(touch_en), .touch_way(touch_way), .rd_entries(rd_entries),
        .rd_valid(rd_valid), .victim_way(victim_way)
    );

    tlb_lookup #(.WAYS(WAYS)) lookup0 (
        .rd_entries(rd_entries), .rd_valid(rd_valid), .vpn(vaddr[31:OFFSET_W]),
        .asid(satp_asid), .hit(hit), .hit_way(hit_way), .hit_entry(hit_entry)
    );

    tlb_perm_check perm0 (
        .check(hit_resp), .pte(hit_entry.pte), .access(access), .priv(priv),
        .walk_fault(walk_fault_out), .fault_load(fault_load),
        .fault_store(fault_store), .fault_insn(fault_insn)
    );

endmodule

`default_nettype wire

/* src/tlb_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_ctrl
    import sv32_pkg::*;
    import tlb_pkg::*;
#(
    parameter int SETS = DEF_SETS,
    parameter int WAYS = DEF_WAYS,
    localparam int SET_W = (SETS > 1) ? $clog2(SETS) : 1,
    localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1
) (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  req,
    input  logic [31:0]           vaddr,
    input  logic [ASID_W-1:0]     satp_asid,
    input  logic                  fence,
    input  logic [31:0]           fence_va,
    input  logic [ASID_W-1:0]     fence_asid,
    input  logic                  hit,
    input  logic [WAY_W-1:0]      hit_way,
    input  tlb_entry_t [WAYS-1:0] rd_entries,
    input  logic [WAYS-1:0]       rd_valid,
    input  logic [WAY_W-1:0]      victim_way,
    input  logic                  walk_busy,
    input  pte_t                  walk_pte,
    input  logic                  walk_fault,
    output logic                  busy,
    output logic                  fence_done,
    output logic                  walk_req,
    output logic [VPN_W-1:0]      walk_vpn,
    output logic                  walk_fault_out,
    output logic [SET_W-1:0]      rd_set,
    output logic                  wr_en,
    output logic                  wr_fill,
    output logic [SET_W-1:0]      wr_set,
    output logic [WAY_W-1:0]      wr_way,
    output tlb_entry_t            wr_entry,
    output logic [WAYS-1:0]       inval_mask,
    output logic                  touch_en,
    output logic [WAY_W-1:0]      touch_way
);

    tlb_state_t        state_q, state_d;
    logic [VPN_W-1:0]  walk_vpn_q;   // vpn/asid of the outstanding miss
    logic [ASID_W-1:0] walk_asid_q;
    logic [SET_W-1:0]  fence_cnt_q;
    logic [VPN_W-1:0]  req_vpn;
    logic [WAYS-1:0]   fence_match;

    function automatic logic [SET_W-1:0] set_of(input logic [VPN_W-1:0] vpn);
        return SET_W'(vpn % SETS);
    endfunction

    assign req_vpn = vaddr[31:OFFSET_W];

    // array read index for each state
    always_comb begin
        case (state_q)
            ST_WALK:  rd_set = set_of(walk_vpn_q);
            ST_FENCE: rd_set = fence_cnt_q;
            default:  rd_set = set_of(req_vpn);
        endcase
    end

    // global pages are immune to an asid-filtered fence
    always_comb begin
        for (int i = 0; i < WAYS; i++) begin
            fence_match[i] = rd_valid[i] &&
                ((fence_va == '0) || (rd_entries[i].vpn == fence_va[31:OFFSET_W])) &&
                ((fence_asid == '0) ||
                 ((rd_entries[i].asid == fence_asid) && !rd_entries[i].pte.global_page));
        end
    end

    always_comb begin
        state_d        = state_q;
        busy           = 1'b1;
        fence_done     = 1'b0;
        walk_req       = 1'b0;
        walk_vpn       = walk_vpn_q;
        walk_fault_out = 1'b0;
        wr_en          = 1'b0;
        wr_fill        = 1'b0;
        wr_set         = set_of(walk_vpn_q);
        wr_way         = victim_way;
        wr_entry       = '{vpn: walk_vpn_q, asid: walk_asid_q, pte: walk_pte};
        inval_mask     = '0;
        touch_en       = 1'b0;
        touch_way      = hit_way;
        case (state_q)
            ST_LOOKUP: begin
                if (fence) begin
                    state_d = ST_FENCE;  // fence beats a pending request
                end else if (req && hit) begin
                    busy     = 1'b0;
                    touch_en = 1'b1;
                end else if (req) begin
                    walk_req = 1'b1;
                    walk_vpn = req_vpn;
                    state_d  = ST_WALK;
                end
            end
            ST_WALK: begin
                walk_req = 1'b1;
                if (!walk_busy) begin
                    state_d = ST_LOOKUP;
                    if (walk_fault) begin
                        busy           = 1'b0;  // fault reported without a fill
                        walk_fault_out = 1'b1;
                    end else begin
                        wr_en   = 1'b1;
                        wr_fill = 1'b1;
                    end
                end
            end
            ST_FENCE: begin
                wr_en      = 1'b1;  // clear only
                inval_mask = fence_match;
                fence_done = (fence_cnt_q == SET_W'(SETS - 1));
                if (fence_done) state_d = ST_LOOKUP;
            end
            default: state_d = ST_LOOKUP;
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state_q     <= ST_LOOKUP;
            fence_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_FENCE) begin
                fence_cnt_q <= fence_done ? '0 : fence_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if ((state_q == ST_LOOKUP) && walk_req) begin
            walk_vpn_q  <= req_vpn;
            walk_asid_q <= satp_asid;
        end
    end

    a_busy_idle: assert property (@(posedge CLK) disable iff (!nRST) !req |-> busy);
    a_done_state: assert property (@(posedge CLK) disable iff (!nRST)
        fence_done |-> (state_q == ST_FENCE));

endmodule

`default_nettype wire

/* src/tlb_perm_check.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_perm_check
    import sv32_pkg::*;
(
    input  logic    check,
    input  pte_t    pte,
    input  access_t access,
    input  priv_t   priv,
    input  logic    walk_fault,
    output logic    fault_load,
    output logic    fault_store,
    output logic    fault_insn
);

    logic denied;

    always_comb begin
        denied = 1'b0;
        if (check) begin
            case (access)
                ACCESS_LOAD:  denied = !pte.readable;
                ACCESS_STORE: denied = !pte.writable;
                ACCESS_FETCH: denied = !pte.executable;
                default:      denied = 1'b1;
            endcase
            if (!pte.valid) denied = 1'b1;
            // user pages are off limits to supervisor, and the other way round
            if (pte.user && (priv == PRIV_SUPERVISOR)) denied = 1'b1;
            if (!pte.user && (priv == PRIV_USER)) denied = 1'b1;
        end
        if (walk_fault) denied = 1'b1;  // walker error, pte is meaningless
    end

    assign fault_load  = denied && (access == ACCESS_LOAD);
    assign fault_store = denied && (access == ACCESS_STORE);
    assign fault_insn  = denied && (access == ACCESS_FETCH);

endmodule

`default_nettype wire

/* src/tlb_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_lookup
    import sv32_pkg::*;
    import tlb_pkg::*;
#(
    parameter int WAYS = DEF_WAYS,
    localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1
) (
    input  tlb_entry_t [WAYS-1:0] rd_entries,
    input  logic [WAYS-1:0]       rd_valid,
    input  logic [VPN_W-1:0]      vpn,
    input  logic [ASID_W-1:0]     asid,
    output logic                  hit,
    output logic [WAY_W-1:0]      hit_way,
    output tlb_entry_t            hit_entry
);

    logic [WAYS-1:0] match;

    always_comb begin
        hit       = 1'b0;
        hit_way   = '0;
        hit_entry = '0;
        for (int i = 0; i < WAYS; i++) begin
            match[i] = rd_valid[i] && (rd_entries[i].vpn == vpn) &&
                       (rd_entries[i].asid == asid);
            if (match[i]) begin
                hit       = 1'b1;
                hit_way   = WAY_W'(i);
                hit_entry = rd_entries[i];
            end
        end
    end

    // fills only happen on a miss, so a second match means a broken fill path
    always_comb begin
        assert ($onehot0(match)) else $error("tlb_lookup: several ways match");
    end

endmodule

`default_nettype wire

/* src/tlb_entry_array.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_entry_array
    import tlb_pkg::*;
#(
    parameter int SETS = DEF_SETS,
    parameter int WAYS = DEF_WAYS,
    localparam int SET_W = (SETS > 1) ? $clog2(SETS) : 1,
    localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1
) (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic [SET_W-1:0]      rd_set,
    input  logic                  wr_en,
    input  logic                  wr_fill,
    input  logic [SET_W-1:0]      wr_set,
    input  logic [WAY_W-1:0]      wr_way,
    input  tlb_entry_t            wr_entry,
    input  logic [WAYS-1:0]       inval_mask,
    input  logic                  touch_en,
    input  logic [WAY_W-1:0]      touch_way,
    output tlb_entry_t [WAYS-1:0] rd_entries,
    output logic [WAYS-1:0]       rd_valid,
    output logic [WAY_W-1:0]      victim_way
);

    tlb_entry_t [WAYS-1:0]      entries_q [SETS];
    logic [SETS-1:0][WAYS-1:0]  valid_q;
    logic [SETS-1:0][WAY_W-1:0] last_used_q;  // mru way per set
    logic [WAY_W-1:0]           last_used;

    // tag and pte payload
    always_ff @(posedge CLK) begin
        if (wr_en && wr_fill) begin
            entries_q[wr_set][wr_way] <= wr_entry;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q     <= '0;
            last_used_q <= '0;
        end else begin
            if (wr_en && wr_fill) begin
                valid_q[wr_set][wr_way] <= 1'b1;
            end else if (wr_en) begin
                valid_q[rd_set] <= valid_q[rd_set] & ~inval_mask;  // fence clear, whole set
            end
            if (touch_en) begin
                last_used_q[rd_set] <= touch_way;
            end
        end
    end

    assign rd_entries = entries_q[rd_set];
    assign rd_valid   = valid_q[rd_set];

    // replace the way after the mru one
    assign last_used  = last_used_q[rd_set];
    assign victim_way = (last_used == WAY_W'(WAYS - 1)) ? '0 : last_used + 1'b1;

    a_wr_way_range: assert property (@(posedge CLK) disable iff (!nRST)
        wr_en |-> (int'(wr_way) < WAYS));

endmodule

`default_nettype wire

/* src/tlb_pkg.sv */
`default_nettype none

package tlb_pkg;

    import sv32_pkg::*;

    // default geometry, 16 sets x 2 ways
    localparam int DEF_SETS = 16;
    localparam int DEF_WAYS = 2;

    // one stored translation, valid bit kept separately
    typedef struct packed {
        logic [VPN_W-1:0]  vpn;    // full vpn, set bits included
        logic [ASID_W-1:0] asid;
        pte_t              pte;
    } tlb_entry_t;

    typedef enum logic [1:0] {
        ST_LOOKUP = 2'd0,
        ST_WALK   = 2'd1,
        ST_FENCE  = 2'd2
    } tlb_state_t;

endpackage

`default_nettype wire

/* src/sv32_pkg.sv */
`default_nettype none

package sv32_pkg;

    // address field widths
    localparam int VPN_W    = 20;
    localparam int OFFSET_W = 12;
    localparam int ASID_W   = 9;
    localparam int PADDR_W  = 34;

    // leaf page table entry, bit 0 is V
    typedef struct packed {
        logic [21:0] ppn;
        logic [1:0]  rsw;          // reserved for software
        logic        dirty;
        logic        accessed;
        logic        global_page;
        logic        user;
        logic        executable;
        logic        writable;
        logic        readable;
        logic        valid;
    } pte_t;

    typedef enum logic [1:0] {
        ACCESS_LOAD  = 2'd0,
        ACCESS_STORE = 2'd1,
        ACCESS_FETCH = 2'd2
    } access_t;

    // machine mode never translates, so only two levels here
    typedef enum logic {
        PRIV_USER       = 1'b0,
        PRIV_SUPERVISOR = 1'b1
    } priv_t;

endpackage

`default_nettype wire
